//--- hdl/game_pkg.sv
package game_pkg;

    // controller states
    typedef enum logic [1:0] {
        S_GREET = 2'd0,
        S_PLAY  = 2'd1,
        S_JUDGE = 2'd2,
        S_WIN   = 2'd3
    } game_state_e;

    // judgement tones
    typedef enum logic [1:0] {
        TONE_HIT  = 2'd0,
        TONE_MISS = 2'd1,
        TONE_WIN  = 2'd2
    } tone_e;

    typedef struct packed {
        logic  valid;
        tone_e tone;
    } beep_req_t;

    typedef struct packed {
        logic [1:0] level;
        logic [3:0] count;
        logic       win;
    } disp_info_t;

    localparam logic [6:0] RAND_SEED  = 7'h5b;
    localparam int         TICK_DIV   = 8;
    localparam int         TICK_W     = $clog2(TICK_DIV);
    localparam logic [3:0] COUNT_FROM = 4'd3;
    localparam int         BEEP_CYCLES = 32;
    localparam int         BEEP_W     = $clog2(BEEP_CYCLES + 1);
    localparam int         HALF_HIT   = 2;
    localparam int         HALF_MISS  = 4;
    localparam int         HALF_WIN   = 1;
    localparam int         HALF_W     = $clog2(HALF_MISS + 1);
    localparam int         SCAN_DIV   = 4;
    localparam int         SCAN_W     = $clog2(SCAN_DIV);

    // segments a..g on bits 0..6, active high
    localparam logic [6:0] SEG_P = 7'h73;

    function automatic logic [6:0] seg_digit(input logic [3:0] d);
        case (d)
            4'd0: return 7'h3f;
            4'd1: return 7'h06;
            4'd2: return 7'h5b;
            4'd3: return 7'h4f;
            4'd4: return 7'h66;
            4'd5: return 7'h6d;
            4'd6: return 7'h7d;
            4'd7: return 7'h07;
            4'd8: return 7'h7f;
            4'd9: return 7'h6f;
            default: return 7'h00;
        endcase
    endfunction

endpackage

//--- hdl/get_random.sv
`timescale 1ns/1ps

module get_random import game_pkg::*; (
    input  logic       clk,
    input  logic       sw,
    input  logic       freeze,
    output logic [6:0] rand_num
);

    logic fb;

    // taps 7 and 6, maximal length over the nonzero states
    assign fb = rand_num[6] ^ rand_num[5];

    always_ff @(posedge clk or posedge sw)
    begin
        if (sw)
            rand_num <= RAND_SEED;
        else if (!freeze)
            rand_num <= {rand_num[5:0], fb};
    end

    // all-zero state would lock the register
    a_never_zero: assert property (@(posedge clk) disable iff (sw) rand_num != 7'd0);

endmodule

//--- hdl/counter.sv
`timescale 1ns/1ps

module counter import game_pkg::*; (
    input  logic       clk,
    input  logic       sw,
    input  logic       cnt_go,
    output logic [3:0] count,
    output logic       over
);

    logic [TICK_W-1:0] presc;
    logic              wrap;

    assign wrap = (presc == TICK_W'(TICK_DIV - 1));

    always_ff @(posedge clk or posedge sw)
    begin
        if (sw)
        begin
            count <= 4'd0;
            presc <= '0;
            over  <= 1'b0;
        end
        else if (cnt_go)
        begin
            count <= COUNT_FROM;
            presc <= '0;
            over  <= 1'b0;
        end
        else if (count != 4'd0)
        begin
            presc <= presc + 1'b1;
            if (wrap)
            begin
                count <= count - 4'd1;
                // last step lands on zero
                if (count == 4'd1)
                    over <= 1'b1;
            end
        end
    end

    a_over_at_zero: assert property (@(posedge clk) disable iff (sw) over |-> count == 4'd0);

endmodule

//--- hdl/beep_beep.sv
`timescale 1ns/1ps

module beep_beep import game_pkg::*; (
    input  logic      clk,
    input  logic      sw,
    input  beep_req_t beep_req,
    output logic      beep
);

    logic [BEEP_W-1:0] len;
    logic [HALF_W-1:0] half;
    logic [HALF_W-1:0] ph;
    logic [HALF_W-1:0] req_half;

    // pitch per tone kind
    always_comb
    begin
        case (beep_req.tone)
            TONE_HIT: req_half = HALF_W'(HALF_HIT);
            TONE_WIN: req_half = HALF_W'(HALF_WIN);
            default:  req_half = HALF_W'(HALF_MISS);
        endcase
    end

    always_ff @(posedge clk or posedge sw)
    begin
        if (sw)
        begin
            len  <= '0;
            half <= HALF_W'(HALF_MISS);
            ph   <= '0;
            beep <= 1'b0;
        end
        else if (beep_req.valid)
        begin
            // a new request restarts the tone
            len  <= BEEP_W'(BEEP_CYCLES);
            half <= req_half;
            ph   <= '0;
            beep <= 1'b1;
        end
        else if (len != '0)
        begin
            len <= len - 1'b1;
            if (len == BEEP_W'(1))
                beep <= 1'b0;
            else if (ph == half - 1'b1)
            begin
                ph   <= '0;
                beep <= ~beep;
            end
            else
                ph <= ph + 1'b1;
        end
    end

    a_quiet_idle: assert property (@(posedge clk) disable iff (sw) len == '0 |-> !beep);

endmodule

//--- hdl/disp_show.sv
`timescale 1ns/1ps

module disp_show import game_pkg::*; (
    input  logic       clk,
    input  logic       sw,
    input  disp_info_t disp_info,
    output logic [7:0] seg,
    output logic [7:0] dig
);

    logic [SCAN_W-1:0] presc;
    logic [1:0]        sel;
    logic [6:0]        pattern;

    // digit scan, three positions
    always_ff @(posedge clk or posedge sw)
    begin
        if (sw)
        begin
            presc <= '0;
            sel   <= 2'd0;
        end
        else if (presc == SCAN_W'(SCAN_DIV - 1))
        begin
            presc <= '0;
            sel   <= (sel == 2'd2) ? 2'd0 : sel + 2'd1;
        end
        else
            presc <= presc + 1'b1;
    end

    always_comb
    begin
        case (sel)
            2'd0:    pattern = seg_digit({2'b00, disp_info.level});
            2'd1:    pattern = seg_digit(disp_info.count);
            default: pattern = disp_info.win ? SEG_P : 7'h00;
        endcase
    end

    // both buses active low, dp kept dark
    assign seg = {1'b1, ~pattern};

    always_comb
    begin
        dig      = 8'hff;
        dig[sel] = 1'b0;
    end

    a_one_digit: assert property (@(posedge clk) disable iff (sw) $onehot(~dig));

endmodule

//--- hdl/game_ctrl.sv
`timescale 1ns/1ps

module game_ctrl import game_pkg::*; (
    input  logic        clk,
    input  logic        sw,
    input  logic        start,
    input  logic        restart,
    input  logic [6:0]  guess,
    input  logic [6:0]  rand_num,
    input  logic        over,
    input  logic [3:0]  count,
    output logic        freeze,
    output logic        cnt_go,
    output beep_req_t   beep_req,
    output disp_info_t  disp_info,
    output logic [15:0] led
);

    game_state_e state;
    logic [1:0]  level;
    logic [6:0]  target;
    logic [2:0]  cleared;
    logic [6:0]  mask;
    logic        hit;
    logic        restart_ok;

    // 5, 6, then 7 bits compared
    assign mask = 7'h7f >> (2'd3 - level);
    assign hit  = ((guess ^ target) & mask) == 7'd0;

    // restart is ignored only while round 1 is under way
    assign restart_ok = restart && (state == S_GREET || state == S_WIN || level >= 2'd2);

    assign freeze = (state != S_GREET);

    assign disp_info.level = level;
    assign disp_info.count = count;
    assign disp_info.win   = (state == S_WIN);

    always_ff @(posedge clk or posedge sw)
    begin
        if (sw)
        begin
            state    <= S_GREET;
            level    <= 2'd1;
            target   <= 7'd0;
            cleared  <= 3'b000;
            cnt_go   <= 1'b0;
            beep_req <= '0;
            led      <= 16'd0;
        end
        else
        begin
            cnt_go         <= 1'b0;
            beep_req.valid <= 1'b0;
            led            <= {5'd0, cleared, 1'b0, freeze ? target : 7'd0};
            if (restart_ok)
            begin
                target  <= rand_num;
                level   <= 2'd1;
                cleared <= 3'b000;
                cnt_go  <= 1'b1;
                state   <= S_PLAY;
            end
            else
            begin
                case (state)
                    S_PLAY:
                    begin
                        // over from the last round is stale while cnt_go is out
                        if (start && over && !cnt_go)
                            state <= S_JUDGE;
                    end
                    S_JUDGE:
                    begin
                        beep_req.valid <= 1'b1;
                        if (hit)
                        begin
                            cleared[level - 2'd1] <= 1'b1;
                            if (level == 2'd3)
                            begin
                                beep_req.tone <= TONE_WIN;
                                state         <= S_WIN;
                            end
                            else
                            begin
                                beep_req.tone <= TONE_HIT;
                                level         <= level + 2'd1;
                                cnt_go        <= 1'b1;
                                state         <= S_PLAY;
                            end
                        end
                        else
                        begin
                            beep_req.tone <= TONE_MISS;
                            cnt_go        <= 1'b1;
                            state         <= S_PLAY;
                        end
                    end
                    default:;
                endcase
            end
        end
    end

    a_level_range: assert property (@(posedge clk) disable iff (sw)
        level >= 2'd1 && level <= 2'd3);

endmodule

//--- hdl/game_top.sv
`timescale 1ns/1ps

module game_top import game_pkg::*; (
    input  logic        clk,
    input  logic        sw,
    input  logic        start,
    input  logic        restart,
    input  logic [6:0]  guess,
    output logic [15:0] led,
    output logic [7:0]  seg,
    output logic [7:0]  dig,
    output logic        beep
);

    logic [6:0] rand_num;
    logic       freeze;
    logic       cnt_go;
    logic [3:0] count;
    logic       over;
    beep_req_t  beep_req;
    disp_info_t disp_info;

    get_random u_get_random (
        .clk      (clk),
        .sw       (sw),
        .freeze   (freeze),
        .rand_num (rand_num)
    );

    counter u_counter (
        .clk    (clk),
        .sw     (sw),
        .cnt_go (cnt_go),
        .count  (count),
        .over   (over)
    );

    beep_beep u_beep_beep (
        .clk      (clk),
        .sw       (sw),
        .beep_req (beep_req),
        .beep     (beep)
    );

    disp_show u_disp_show (
        .clk       (clk),
        .sw        (sw),
        .disp_info (disp_info),
        .seg       (seg),
        .dig       (dig)
    );

    // count is routed through the controller into the display info
    game_ctrl u_game_ctrl (
        .clk       (clk),
        .sw        (sw),
        .start     (start),
        .restart   (restart),
        .guess     (guess),
        .rand_num  (rand_num),
        .over      (over),
        .count     (count),
        .freeze    (freeze),
        .cnt_go    (cnt_go),
        .beep_req  (beep_req),
        .disp_info (disp_info),
        .led       (led)
    );

endmodule

//--- sim/tb_game_top.sv
`timescale 1ns/1ps

module tb_game_top import game_pkg::*; ();

    logic        clk;
    logic        sw;
    logic        start;
    logic        restart;
    logic [6:0]  guess;
    logic [15:0] led;
    logic [7:0]  seg;
    logic [7:0]  dig;
    logic        beep;

    // player model
    int          cyc;
    logic        game_on;
    logic        steady;
    int          m_level;
    logic [6:0]  m_target;
    logic [2:0]  m_cleared;
    logic        m_win;
    int          m_half;
    int          tone_base;
    logic        tone_armed;
    int          cnt_base;
    logic        cnt_armed;
    logic [31:0] lfsr_state;

    game_top u_game_top (
        .clk     (clk),
        .sw      (sw),
        .start   (start),
        .restart (restart),
        .guess   (guess),
        .led     (led),
        .seg     (seg),
        .dig     (dig),
        .beep    (beep)
    );

    always #2 clk = ~clk;

    always @(posedge clk)
        cyc <= cyc + 1;

    task automatic fail_value(input string what);
        $display("[FAIL] %0t ns: %s", $time, what);
        $display("Simulation failed");
        $fatal(1, "check failed");
    endtask

    task automatic fail_timeout(input string what);
        $display("timeout while waiting for %s", what);
        $display("Simulation failed");
        $fatal(1, "wait timed out");
    endtask

    // common anode codes, dp dark
    function automatic logic [7:0] seg_code(input int d);
        case (d)
            0: return 8'hc0;
            1: return 8'hf9;
            2: return 8'ha4;
            3: return 8'hb0;
            default: return 8'hff;
        endcase
    endfunction

    function automatic int exp_count(input int now, input int base, input logic armed);
        int el;
        el = now - base;
        if (!armed || el < 0 || el >= int'(COUNT_FROM) * TICK_DIV)
            return 0;
        return int'(COUNT_FROM) - el / TICK_DIV;
    endfunction

    function automatic logic exp_beep(input int now, input int base, input logic armed,
                                      input int half);
        int k;
        k = now - base;
        if (!armed || k < 0 || k >= BEEP_CYCLES)
            return 1'b0;
        return ((k / half) % 2) == 0;
    endfunction

    // taps 32, 22, 2 and 1
    function automatic logic lfsr_bit();
        logic fb;
        fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
        lfsr_state = {lfsr_state[30:0], fb};
        return fb;
    endfunction

    function automatic logic [6:0] rand7();
        logic [6:0] r;
        for (int i = 0; i < 7; i++)
            r[i] = lfsr_bit();
        return r;
    endfunction

    // low 4+level bits take part in the compare
    function automatic logic [6:0] judged_bits(input int level);
        return 7'((1 << (4 + level)) - 1);
    endfunction

    function automatic logic [6:0] wrong_guess();
        logic [6:0] r;
        r = rand7();
        if ((r & judged_bits(m_level)) == 7'd0)
            r[0] = 1'b1;
        return m_target ^ r;
    endfunction

    // noise only above the judged bits
    function automatic logic [6:0] right_guess();
        return m_target ^ (rand7() & ~judged_bits(m_level));
    endfunction

    a_scan: assert property (@(posedge clk) disable iff (sw)
        $onehot(~dig[2:0]) && dig[7:3] == 5'h1f)
        else fail_value($sformatf("digit enables %b", dig));

    a_idle: assert property (@(posedge clk) disable iff (sw)
        !game_on |-> (led == 16'd0 && !beep))
        else fail_value($sformatf("before restart led %h beep %b", led, beep));

    a_target: assert property (@(posedge clk) disable iff (sw)
        (game_on && steady) |-> (led[6:0] == m_target && m_target != 7'd0))
        else fail_value($sformatf("target led %h, model %h", led[6:0], m_target));

    a_progress: assert property (@(posedge clk) disable iff (sw)
        steady |-> (led[15:7] == {5'd0, m_cleared, 1'b0}))
        else fail_value($sformatf("progress led %h, model %b", led[15:7], m_cleared));

    a_level: assert property (@(posedge clk) disable iff (sw)
        (steady && !dig[0]) |-> (seg == seg_code(m_level)))
        else fail_value($sformatf("level digit %h, model %0d", seg, m_level));

    a_count: assert property (@(posedge clk) disable iff (sw)
        (steady && !dig[1]) |-> (seg == seg_code(exp_count(cyc, cnt_base, cnt_armed))))
        else fail_value($sformatf("count digit %h", seg));

    a_win: assert property (@(posedge clk) disable iff (sw)
        (steady && !dig[2]) |-> (seg == (m_win ? 8'h8c : 8'hff)))
        else fail_value($sformatf("win digit %h, model %b", seg, m_win));

    a_tone: assert property (@(posedge clk) disable iff (sw)
        steady |-> (beep == exp_beep(cyc, tone_base, tone_armed, m_half)))
        else fail_value($sformatf("beep %b, half period %0d", beep, m_half));

    task automatic run_cycles(input int n);
        repeat (n) @(negedge clk);
    endtask

    task automatic wait_cycle(input int target);
        int n;
        n = 0;
        while (cyc != target && n < 64)
        begin
            @(negedge clk);
            n++;
        end
        if (cyc != target)
            fail_timeout($sformatf("cycle %0d", target));
    endtask

    task automatic wait_count_zero();
        int n;
        n = 0;
        while (!(dig[1] == 1'b0 && seg == seg_code(0)) && n < 200)
        begin
            @(negedge clk);
            n++;
        end
        if (!(dig[1] == 1'b0 && seg == seg_code(0)))
            fail_timeout("the countdown to show zero");
    endtask

    // called on a falling edge
    task automatic restart_game();
        int c;
        restart = 1'b1;
        c = cyc;
        steady = 1'b0;
        game_on = 1'b1;
        @(negedge clk);
        restart = 1'b0;
        wait_cycle(c + 3);
        m_target = led[6:0];
        m_level = 1;
        m_cleared = 3'b000;
        m_win = 1'b0;
        cnt_base = c + 2;
        cnt_armed = 1'b1;
        steady = 1'b1;
    endtask

    task automatic early_start();
        start = 1'b1;
        @(negedge clk);
        start = 1'b0;
        run_cycles(BEEP_CYCLES);
    endtask

    task automatic judge_guess(input logic [6:0] g);
        int   c;
        logic hit;
        guess = g;
        hit = ((g ^ m_target) & judged_bits(m_level)) == 7'd0;
        wait_count_zero();
        start = 1'b1;
        c = cyc;
        steady = 1'b0;
        @(negedge clk);
        start = 1'b0;
        wait_cycle(c + 3);
        // tone and new countdown both start two edges after the press
        tone_base = c + 3;
        tone_armed = 1'b1;
        if (!hit)
        begin
            m_half = HALF_MISS;
            cnt_base = c + 3;
        end
        else
        begin
            m_cleared[m_level - 1] = 1'b1;
            if (m_level == 3)
            begin
                m_half = HALF_WIN;
                m_win = 1'b1;
            end
            else
            begin
                m_half = HALF_HIT;
                m_level++;
                cnt_base = c + 3;
            end
        end
        steady = 1'b1;
    endtask

    initial
    begin
        clk = 1'b0;
        sw = 1'b1;
        start = 1'b0;
        restart = 1'b0;
        guess = 7'd0;
        cyc = 0;
        game_on = 1'b0;
        steady = 1'b1;
        m_level = 1;
        m_target = 7'd0;
        m_cleared = 3'b000;
        m_win = 1'b0;
        m_half = HALF_MISS;
        tone_base = 0;
        tone_armed = 1'b0;
        cnt_base = 0;
        cnt_armed = 1'b0;
        lfsr_state = 32'h8507_943d;
        repeat (8) @(negedge clk);
        sw = 1'b0;
        run_cycles(BEEP_CYCLES);

        restart_game();
        early_start();
        judge_guess(wrong_guess());
        judge_guess(right_guess());
        judge_guess(right_guess());
        // a miss in the last round replays it
        judge_guess(wrong_guess());
        judge_guess(right_guess());
        run_cycles(2 * BEEP_CYCLES);

        restart_game();
        judge_guess(right_guess());
        // restart while round 2 counts down
        restart_game();
        judge_guess(wrong_guess());
        run_cycles(BEEP_CYCLES);

        $display("Simulation completed successfully");
        $finish;
    end

endmodule

//--- project.f
hdl/game_pkg.sv
hdl/get_random.sv
hdl/counter.sv
hdl/beep_beep.sv
hdl/disp_show.sv
hdl/game_ctrl.sv
hdl/game_top.sv
sim/tb_game_top.sv

//--- Makefile
BIN := obj_dir/Vtb_game_top

.PHONY: all run clean

all: run

$(BIN): project.f $(wildcard hdl/*.sv) $(wildcard sim/*.sv)
	verilator --binary --timing --assert --top-module tb_game_top -f project.f

run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Simulation completed successfully"

clean:
	rm -rf obj_dir
